// File: lsu_pkg.sv
// lsu package: widths, opcodes, exception causes and bus structs of the load/store unit
package lsu_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned TRANS_ID_BITS = 3;
  localparam int unsigned BE_BITS       = 4;

  // ----------------------------------------
  // opcodes and exception causes
  // ----------------------------------------
  typedef enum logic [3:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW,
    NOP
  } lsu_op_e;

  // riscv mcause encodings
  typedef enum logic [4:0] {
    LD_ADDR_MISALIGNED = 5'd4,
    ST_ADDR_MISALIGNED = 5'd6
  } exc_cause_e;

  // ----------------------------------------
  // structs
  // ----------------------------------------
  // from the issue stage
  typedef struct packed {
    lsu_op_e                  op;
    logic [XLEN-1:0]          operand_a;
    logic [XLEN-1:0]          imm;
    logic [XLEN-1:0]          operand_b;
    logic [TRANS_ID_BITS-1:0] trans_id;
  } lsu_issue_t;

  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  // one buffered request
  typedef struct packed {
    logic                     is_store;
    lsu_op_e                  op;
    logic [XLEN-1:0]          vaddr;
    logic [XLEN-1:0]          wdata;
    logic [BE_BITS-1:0]       be;
    logic [TRANS_ID_BITS-1:0] trans_id;
    exception_t               ex;
  } lsu_ctrl_t;

  typedef struct packed {
    logic               req;
    logic               we;
    logic [XLEN-1:0]    addr;
    logic [BE_BITS-1:0] be;
    logic [XLEN-1:0]    wdata;
  } mem_req_t;

  typedef struct packed {
    logic            rvalid;
    logic [XLEN-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                     valid;
    logic [TRANS_ID_BITS-1:0] trans_id;
    logic [XLEN-1:0]          result;
    exception_t               ex;
  } lsu_result_t;

endpackage

// File: lsu_agu.sv
// lsu_agu: address generation, byte enables, store data alignment and misalignment check
`timescale 1ns/1ps

module lsu_agu import lsu_pkg::*; (
  input  lsu_issue_t issue_i,
  output lsu_ctrl_t  ctrl_o
);

  logic [XLEN-1:0]    vaddr;
  logic               is_store;
  // 0 byte, 1 halfword, 2 word
  logic [1:0]         size;
  logic [BE_BITS-1:0] be;
  logic               misaligned;

  assign vaddr = issue_i.operand_a + issue_i.imm;

  // ----------------------------------------
  // op decode
  // ----------------------------------------
  always_comb begin
    is_store = 1'b0;
    size     = 2'd0;
    case (issue_i.op)
      LH, LHU: size = 2'd1;
      LW:      size = 2'd2;
      SB: begin
        is_store = 1'b1;
      end
      SH: begin
        is_store = 1'b1;
        size     = 2'd1;
      end
      SW: begin
        is_store = 1'b1;
        size     = 2'd2;
      end
      default: ;
    endcase
  end

  // ----------------------------------------
  // byte enables and alignment
  // ----------------------------------------
  always_comb begin
    case (size)
      2'd0:    be = 4'b0001 << vaddr[1:0];
      2'd1:    be = 4'b0011 << vaddr[1:0];
      default: be = 4'b1111;
    endcase
  end

  assign misaligned = ((size == 2'd1) && vaddr[0]) ||
                      ((size == 2'd2) && (vaddr[1:0] != 2'b00));

  always_comb begin
    ctrl_o.is_store = is_store;
    ctrl_o.op       = issue_i.op;
    ctrl_o.vaddr    = vaddr;
    // store data moved into its byte lane
    ctrl_o.wdata    = issue_i.operand_b << {vaddr[1:0], 3'b000};
    ctrl_o.be       = be;
    ctrl_o.trans_id = issue_i.trans_id;
    ctrl_o.ex.valid = misaligned;
    ctrl_o.ex.cause = is_store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
    ctrl_o.ex.tval  = misaligned ? vaddr : '0;
  end

  // catches garbage from the issue stage
  always_comb begin
    if (!$isunknown(issue_i.op)) begin
      assert (issue_i.op inside {LB, LH, LW, LBU, LHU, SB, SH, SW, NOP})
        else $error("lsu_agu: illegal op %0d", issue_i.op);
    end
  end

endmodule

// File: lsu_req_buffer.sv
// lsu_req_buffer: circular FIFO of requests between the AGU and the load/store units
`timescale 1ns/1ps

module lsu_req_buffer import lsu_pkg::*; #(
  parameter int unsigned BUF_DEPTH = 2
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  lsu_ctrl_t data_i,
  input  logic      pop_i,
  output lsu_ctrl_t head_o,
  output logic      head_valid_o,
  output logic      ready_o
);

  localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
  localparam int unsigned CNT_W = $clog2(BUF_DEPTH + 1);

  lsu_ctrl_t        mem_q [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  assign head_o       = mem_q[rd_ptr_q];
  assign head_valid_o = (count_q != '0);
  assign ready_o      = (count_q != CNT_W'(BUF_DEPTH));

  // ----------------------------------------
  // pointers and fill level
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the top must respect ready_o and the units may only consume a valid head
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> ready_o)
    else $error("lsu_req_buffer: push while full");
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> head_valid_o)
    else $error("lsu_req_buffer: pop while empty");

endmodule

// File: lsu_load_unit.sv
// lsu_load_unit: issues memory reads for the buffer head and extends the returned data
`timescale 1ns/1ps

module lsu_load_unit import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  lsu_ctrl_t   head_i,
  input  logic        head_valid_i,
  output logic        busy_o,
  output logic        pop_ld_o,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,
  output lsu_result_t result_o
);

  typedef enum logic {
    IDLE,
    WAIT_RSP
  } state_e;

  state_e                   state_q;
  logic                     issue_rd;
  logic                     ex_pop;
  logic                     rsp_done;
  // pending request
  lsu_op_e                  op_q;
  logic [1:0]               offset_q;
  logic [TRANS_ID_BITS-1:0] trans_id_q;
  // result register
  logic                     res_valid_q;
  logic [TRANS_ID_BITS-1:0] res_id_q;
  logic [XLEN-1:0]          res_data_q;
  exception_t               res_ex_q;
  logic [XLEN-1:0]          rshift;
  logic [XLEN-1:0]          ld_data;

  assign busy_o   = (state_q != IDLE);
  assign pop_ld_o = (state_q == IDLE) && head_valid_i && !head_i.is_store;
  assign ex_pop   = pop_ld_o && head_i.ex.valid;
  assign issue_rd = pop_ld_o && !head_i.ex.valid;
  assign rsp_done = (state_q == WAIT_RSP) && mem_rsp_i.rvalid;

  // word read, the memory returns the full word
  always_comb begin
    mem_req_o      = '0;
    mem_req_o.req  = issue_rd;
    mem_req_o.addr = {head_i.vaddr[XLEN-1:2], 2'b00};
    mem_req_o.be   = head_i.be;
  end

  // ----------------------------------------
  // byte select and extension
  // ----------------------------------------
  assign rshift = mem_rsp_i.rdata >> {offset_q, 3'b000};

  always_comb begin
    case (op_q)
      LB:      ld_data = {{(XLEN-8){rshift[7]}}, rshift[7:0]};
      LBU:     ld_data = {{(XLEN-8){1'b0}}, rshift[7:0]};
      LH:      ld_data = {{(XLEN-16){rshift[15]}}, rshift[15:0]};
      LHU:     ld_data = {{(XLEN-16){1'b0}}, rshift[15:0]};
      default: ld_data = mem_rsp_i.rdata;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= ex_pop || rsp_done;
      case (state_q)
        IDLE:     if (issue_rd) state_q <= WAIT_RSP;
        WAIT_RSP: if (mem_rsp_i.rvalid) state_q <= IDLE;
        default:  state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_rd) begin
      op_q       <= head_i.op;
      offset_q   <= head_i.vaddr[1:0];
      trans_id_q <= head_i.trans_id;
    end
    if (ex_pop) begin
      res_id_q   <= head_i.trans_id;
      res_data_q <= '0;
      res_ex_q   <= head_i.ex;
    end else if (rsp_done) begin
      res_id_q   <= trans_id_q;
      res_data_q <= ld_data;
      res_ex_q   <= '0;
    end
  end

  always_comb begin
    result_o.valid    = res_valid_q;
    result_o.trans_id = res_id_q;
    result_o.result   = res_data_q;
    result_o.ex       = res_ex_q;
  end

  // memory must only answer a read that was issued
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (state_q == IDLE) |-> !mem_rsp_i.rvalid)
    else $error("lsu_load_unit: rvalid without pending read");

endmodule

// File: lsu_store_unit.sv
// lsu_store_unit: writes store heads to memory and reports their completion
`timescale 1ns/1ps

module lsu_store_unit import lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  lsu_ctrl_t   head_i,
  input  logic        head_valid_i,
  input  logic        ld_busy_i,
  output logic        pop_st_o,
  output mem_req_t    mem_req_o,
  output lsu_result_t result_o
);

  logic                     res_valid_q;
  logic [TRANS_ID_BITS-1:0] res_id_q;
  exception_t               res_ex_q;

  // wait behind an outstanding load to keep order
  assign pop_st_o = head_valid_i && head_i.is_store && !ld_busy_i;

  // ----------------------------------------
  // memory write
  // ----------------------------------------
  always_comb begin
    mem_req_o.req   = pop_st_o && !head_i.ex.valid;
    mem_req_o.we    = 1'b1;
    mem_req_o.addr  = {head_i.vaddr[XLEN-1:2], 2'b00};
    mem_req_o.be    = head_i.be;
    mem_req_o.wdata = head_i.wdata;
  end

  // ----------------------------------------
  // completion
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= pop_st_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_st_o) begin
      res_id_q <= head_i.trans_id;
      res_ex_q <= head_i.ex;
    end
  end

  // stores return no data
  always_comb begin
    result_o.valid    = res_valid_q;
    result_o.trans_id = res_id_q;
    result_o.result   = '0;
    result_o.ex       = res_ex_q;
  end

endmodule

// File: lsu_result_pipe.sv
// lsu_result_pipe: register chain of configurable depth on one result port
`timescale 1ns/1ps

module lsu_result_pipe import lsu_pkg::*; #(
  parameter int unsigned DEPTH = 1
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  lsu_result_t result_i,
  output lsu_result_t result_o
);

  if (DEPTH == 0) begin : gen_bypass
    assign result_o = result_i;
  end else begin : gen_stages
    logic [DEPTH-1:0] valid_q;
    lsu_result_t      stage_q [DEPTH];

    // valid bits
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= result_i.valid;
        for (int i = 1; i < DEPTH; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    // payload
    always_ff @(posedge clk_i) begin
      stage_q[0] <= result_i;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end

    always_comb begin
      result_o       = stage_q[DEPTH-1];
      result_o.valid = valid_q[DEPTH-1];
    end
  end

endmodule

// File: lsu_top.sv
// lsu_top: load/store unit with request queue, load and store units and result pipes
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned BUF_DEPTH     = 2,
  parameter int unsigned LD_PIPE_DEPTH = 1,
  parameter int unsigned ST_PIPE_DEPTH = 1
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        valid_i,
  input  lsu_issue_t  issue_i,
  output logic        ready_o,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i,
  output lsu_result_t load_result_o,
  output lsu_result_t store_result_o
);

  lsu_ctrl_t   agu_ctrl;
  lsu_ctrl_t   head;
  logic        head_valid;
  logic        push;
  logic        pop_ld;
  logic        pop_st;
  logic        ld_busy;
  mem_req_t    ld_mem_req;
  mem_req_t    st_mem_req;
  lsu_result_t ld_result;
  lsu_result_t st_result;

  assign push = valid_i && ready_o;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  lsu_agu u_agu (
    .issue_i (issue_i),
    .ctrl_o  (agu_ctrl)
  );

  lsu_req_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_req_buffer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .data_i       (agu_ctrl),
    .pop_i        (pop_ld || pop_st),
    .head_o       (head),
    .head_valid_o (head_valid),
    .ready_o      (ready_o)
  );

  // ----------------------------------------
  // processing
  // ----------------------------------------
  lsu_load_unit u_load_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .head_valid_i (head_valid),
    .busy_o       (ld_busy),
    .pop_ld_o     (pop_ld),
    .mem_req_o    (ld_mem_req),
    .mem_rsp_i    (mem_rsp_i),
    .result_o     (ld_result)
  );

  lsu_store_unit u_store_unit (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .head_i       (head),
    .head_valid_i (head_valid),
    .ld_busy_i    (ld_busy),
    .pop_st_o     (pop_st),
    .mem_req_o    (st_mem_req),
    .result_o     (st_result)
  );

  // load request has priority, dispatch keeps them apart anyway
  assign mem_req_o = ld_mem_req.req ? ld_mem_req : st_mem_req;

  // ----------------------------------------
  // output side
  // ----------------------------------------
  lsu_result_pipe #(
    .DEPTH (LD_PIPE_DEPTH)
  ) u_ld_pipe (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .result_i (ld_result),
    .result_o (load_result_o)
  );

  lsu_result_pipe #(
    .DEPTH (ST_PIPE_DEPTH)
  ) u_st_pipe (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .result_i (st_result),
    .result_o (store_result_o)
  );

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   !(ld_mem_req.req && st_mem_req.req))
    else $error("lsu_top: load and store unit request memory together");

endmodule

// File: tb_data_mem.sv
// tb_data_mem: behavioural word memory with byte enables and random read latency
`timescale 1ns/1ps

module tb_data_mem import lsu_pkg::*; #(
  parameter int unsigned WORDS = 256
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  localparam int unsigned AW = $clog2(WORDS);

  logic [XLEN-1:0] words [WORDS];
  logic            pend_q;
  logic [2:0]      wait_q;
  logic [AW-1:0]   raddr_q;
  logic [AW-1:0]   idx;

  assign idx = mem_req_i.addr[AW+1:2];

  // every byte of a word derived from its index
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      words[i] = {8'(i) ^ 8'ha5, 8'(i) + 8'h3c, ~8'(i), 8'(i)};
    end
  end

  // writes land at the request edge
  always @(posedge clk_i) begin
    if (mem_req_i.req && mem_req_i.we) begin
      for (int b = 0; b < BE_BITS; b++) begin
        if (mem_req_i.be[b]) begin
          words[idx][8*b +: 8] <= mem_req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // one read in flight, answered after 1 to 4 cycles
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q    <= 1'b0;
      wait_q    <= '0;
      raddr_q   <= '0;
      mem_rsp_o <= '0;
    end else begin
      mem_rsp_o.rvalid <= 1'b0;
      if (mem_req_i.req && !mem_req_i.we) begin
        pend_q  <= 1'b1;
        wait_q  <= 3'($urandom_range(4, 1));
        raddr_q <= idx;
      end else if (pend_q) begin
        if (wait_q == 3'd1) begin
          mem_rsp_o.rvalid <= 1'b1;
          mem_rsp_o.rdata  <= words[raddr_q];
          pend_q           <= 1'b0;
        end else begin
          wait_q <= wait_q - 3'd1;
        end
      end
    end
  end

endmodule

// File: tb_lsu.sv
// tb_lsu: testbench for the load/store unit with shadow memory and result scoreboards
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

  localparam int CLK_HALF       = 20;
  // 56 + 26 + 12 + 16 + 8 requests over the tests below
  localparam int NUM_REQ        = 118;
  localparam int TIMEOUT_CYCLES = NUM_REQ * 10 + 200;

  logic        clk_i;
  logic        rst_ni;
  logic        valid_i;
  lsu_issue_t  issue;
  logic        ready;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  lsu_result_t ld_res;
  lsu_result_t st_res;

  // scoreboard state
  logic [31:0] shadow [256];
  lsu_result_t ld_exp [$];
  lsu_result_t st_exp [$];
  logic [2:0]  next_id;
  int          err_cnt = 0;
  int          err_base = 0;
  int          n_checks = 0;
  int          n_tests = 0;
  logic        bp_seen;
  logic        no_mem_q = 1'b0;
  logic        lat_chk = 1'b0;
  logic        acc_n = 1'b0;
  logic [2:0]  acc_id_n = '0;
  logic [2:0]  st_acc_sr = '0;
  logic [8:0]  st_id_sr = '0;

  lsu_top dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid_i        (valid_i),
    .issue_i        (issue),
    .ready_o        (ready),
    .mem_req_o      (mem_req),
    .mem_rsp_i      (mem_rsp),
    .load_result_o  (ld_res),
    .store_result_o (st_res)
  );

  tb_data_mem #(
    .WORDS (256)
  ) mem0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic logic [31:0] load_value(lsu_op_e op, logic [31:0] word, int o);
    logic [31:0] sh;
    sh = word >> (8 * o);
    case (op)
      LB:      return {{24{sh[7]}}, sh[7:0]};
      LBU:     return {24'h0, sh[7:0]};
      LH:      return {{16{sh[15]}}, sh[15:0]};
      LHU:     return {16'h0, sh[15:0]};
      default: return word;
    endcase
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
    n_checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t %s expected 0x%08h got 0x%08h", $time, name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic compare_result(string port, lsu_result_t exp, lsu_result_t got);
    check_value({port, ".trans_id"}, 32'(exp.trans_id), 32'(got.trans_id));
    check_value({port, ".result"}, exp.result, got.result);
    check_value({port, ".ex.valid"}, 32'(exp.ex.valid), 32'(got.ex.valid));
    if (exp.ex.valid) begin
      check_value({port, ".ex.cause"}, 32'(exp.ex.cause), 32'(got.ex.cause));
      check_value({port, ".ex.tval"}, exp.ex.tval, got.ex.tval);
    end
  endtask

  // records the expected result, then holds valid until the request is taken
  task automatic send(lsu_op_e op, logic [31:0] base, logic [31:0] imm, logic [31:0] data);
    lsu_result_t exp;
    logic [31:0] addr;
    logic        store;
    int          size;
    int          o;
    addr  = base + imm;
    o     = int'(addr[1:0]);
    store = op inside {SB, SH, SW};
    size  = (op inside {LW, SW}) ? 4 : (op inside {LH, LHU, SH}) ? 2 : 1;
    exp          = '0;
    exp.valid    = 1'b1;
    exp.trans_id = next_id;
    if ((o % size) != 0) begin
      exp.ex.valid = 1'b1;
      exp.ex.cause = store ? ST_ADDR_MISALIGNED : LD_ADDR_MISALIGNED;
      exp.ex.tval  = addr;
    end else if (store) begin
      for (int k = 0; k < size; k++) begin
        shadow[addr[9:2]][8*(o+k) +: 8] = data[8*k +: 8];
      end
    end else begin
      exp.result = load_value(op, shadow[addr[9:2]], o);
    end
    if (store) begin
      st_exp.push_back(exp);
    end else begin
      ld_exp.push_back(exp);
    end
    issue.op        = op;
    issue.operand_a = base;
    issue.imm       = imm;
    issue.operand_b = data;
    issue.trans_id  = next_id;
    valid_i         = 1'b1;
    while (!ready) begin
      bp_seen = 1'b1;
      @(posedge clk_i);
      #2;
    end
    @(posedge clk_i);
    #2;
    valid_i = 1'b0;
    next_id = next_id + 3'd1;
  endtask

  task automatic drain();
    while (ld_exp.size() != 0 || st_exp.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    #2;
  endtask

  task automatic start_test();
    err_base = err_cnt;
  endtask

  task automatic end_test(string name);
    n_tests++;
    $display("%-24s %s", name, (err_cnt == err_base) ? "ok" : "errors");
  endtask

  // ----------------------------------------
  // checkers
  // ----------------------------------------
  always @(negedge clk_i) begin
    if (rst_ni && ld_res.valid) begin
      if (ld_exp.size() == 0) begin
        $display("unexpected load result at %0t with no load outstanding", $time);
        err_cnt++;
      end else begin
        compare_result("load_result_o", ld_exp.pop_front(), ld_res);
      end
    end
    if (rst_ni && st_res.valid) begin
      if (st_exp.size() == 0) begin
        $display("unexpected store result at %0t with no store outstanding", $time);
        err_cnt++;
      end else begin
        compare_result("store_result_o", st_exp.pop_front(), st_res);
      end
    end
  end

  // store acceptance, delayed to line up with its result
  always @(negedge clk_i) begin
    acc_n    <= lat_chk && valid_i && ready && (issue.op inside {SB, SH, SW});
    acc_id_n <= issue.trans_id;
  end

  always @(posedge clk_i) begin
    st_acc_sr <= {st_acc_sr[1:0], acc_n};
    st_id_sr  <= {st_id_sr[5:0], acc_id_n};
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   st_acc_sr[2] |-> st_res.valid && (st_res.trans_id == st_id_sr[8:6]))
    else begin
      $display("[ERROR] %0t store_result_o expected valid 1 id %0d got valid %0b id %0d",
               $time, $sampled(st_id_sr[8:6]), $sampled(st_res.valid),
               $sampled(st_res.trans_id));
      err_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) no_mem_q |-> !mem_req.req)
    else begin
      $display("[ERROR] %0t mem_req_o.req expected 0 got 1", $time);
      err_cnt++;
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   mem_req.req |-> (mem_req.addr[1:0] == 2'b00))
    else begin
      $display("[ERROR] %0t mem_req_o.addr[1:0] expected 0 got %0d",
               $time, $sampled(mem_req.addr[1:0]));
      err_cnt++;
    end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout after %0d cycles, the LSU stopped returning results", TIMEOUT_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    logic [31:0] base;
    void'($urandom(32'h26a7));
    rst_ni   = 1'b0;
    valid_i  = 1'b0;
    issue    = '0;
    issue.op = NOP;
    next_id  = '0;
    bp_seen  = 1'b0;
    for (int i = 0; i < 256; i++) begin
      shadow[i] = {8'(i) ^ 8'ha5, 8'(i) + 8'h3c, ~8'(i), 8'(i)};
    end
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    start_test();
    check_value("ready_o", 32'd1, 32'(ready));
    check_value("mem_req_o.req", 32'd0, 32'(mem_req.req));
    check_value("load_result_o.valid", 32'd0, 32'(ld_res.valid));
    check_value("store_result_o.valid", 32'd0, 32'(st_res.valid));
    end_test("reset state");

    start_test();
    for (int w = 0; w < 4; w++) begin
      base = 32'h80 + 32'(w) * 32;
      send(SW, base, 32'd4, $urandom());
      for (int o = 0; o < 4; o++) begin
        send(LB, base, 32'(4 + o), '0);
        send(LBU, base, 32'(4 + o), '0);
      end
      for (int o = 0; o < 4; o += 2) begin
        send(LH, base, 32'(4 + o), '0);
        send(LHU, base, 32'(4 + o), '0);
      end
      send(LW, base, 32'd4, '0);
    end
    drain();
    end_test("aligned store and load");

    // negative immediate, byte lanes read back as words
    start_test();
    for (int w = 0; w < 2; w++) begin
      base = 32'h20c + 32'(w) * 4;
      send(SW, base, 32'hffff_fff4, $urandom());
      for (int o = 0; o < 4; o++) begin
        send(SB, base, 32'hffff_fff4 + 32'(o), $urandom());
        send(LW, base, 32'hffff_fff4, '0);
      end
      for (int o = 0; o < 4; o += 2) begin
        send(SH, base, 32'hffff_fff4 + 32'(o), $urandom());
        send(LW, base, 32'hffff_fff4, '0);
      end
    end
    drain();
    end_test("store byte lanes");

    start_test();
    no_mem_q = 1'b1;
    for (int o = 1; o < 4; o += 2) begin
      send(LH, 32'h140, 32'(o), '0);
      send(LHU, 32'h140, 32'(o), '0);
      send(SH, 32'h140, 32'(o), $urandom());
    end
    for (int o = 1; o < 4; o++) begin
      send(LW, 32'h180, 32'(o), '0);
      send(SW, 32'h180, 32'(o), $urandom());
    end
    drain();
    no_mem_q = 1'b0;
    end_test("misalignment");

    start_test();
    bp_seen = 1'b0;
    for (int i = 0; i < 16; i++) begin
      send(LW, 32'h80, 32'(4 * i), '0);
    end
    drain();
    assert (bp_seen) else begin
      $display("ready_o never went low during the load burst");
      err_cnt++;
    end
    end_test("back-pressure");

    start_test();
    lat_chk = 1'b1;
    for (int i = 0; i < 8; i++) begin
      case (i % 3)
        0:       send(SW, 32'h300, 32'(4 * i), $urandom());
        1:       send(SB, 32'h300, 32'(4 * i + i % 4), $urandom());
        default: send(SH, 32'h300, 32'(4 * i + 2), $urandom());
      endcase
    end
    drain();
    lat_chk = 1'b0;
    end_test("store latency");

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
lsu_pkg.sv
lsu_agu.sv
lsu_req_buffer.sv
lsu_load_unit.sv
lsu_store_unit.sv
lsu_result_pipe.sv
lsu_top.sv
tb_data_mem.sv
tb_lsu.sv

// File: Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_lsu
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
